// ==== list.f ====
src/cpu_pkg.sv
src/regfile.sv
src/decoder.sv
src/id_stage.sv
src/if_stage.sv
src/ex_stage.sv
src/unified_mem.sv
src/cpu_top.sv
dv/cpu_asserts.sv
dv/cpu_tb.sv

// ==== Makefile ====
# Verilator flow for the core and its testbench

VERILATOR  = verilator
TOP        = cpu_tb
FLIST      = list.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = test failed
PASS_MSG   = test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended early, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/cpu_tb.sv ====
// cpu_tb: table-driven testbench, loads small programs, checks writebacks, flags and stores
`timescale 1ns/1ps

module cpu_tb;
  import cpu_pkg::*;

  logic     clock, arst_n, run, ext_req, ext_we;
  addr_t    ext_addr;
  word_t    ext_wr_data, ext_rd_data, wb_data;
  logic     ext_gnt, wb_en, halted, illegal;
  reg_idx_t wb_idx;

  // one stimulus row, outcome 0 = result, 1 = halt, 2 = illegal
  typedef struct {
    string      name;
    logic [5:0] op;
    logic [6:0] func;
    bit         lit;
    logic [15:0] imm;        // literal in [7:0] or displacement
    reg_idx_t   src_a;
    reg_idx_t   dst;
    word_t      opa, opb;
    int         outcome;
  } entry_t;

  entry_t table_q [$];
  integer seed;
  int     errors, checks;
  bit     timed_out;

  cpu_top uut (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;  // 100 ns period
  end

  //////////////////////////////////////////////////
  // encoders and reference rules
  //////////////////////////////////////////////////
  function automatic logic [31:0] enc_mem(logic [5:0] op, reg_idx_t ra, reg_idx_t rb,
                                          logic [15:0] disp);
    return {op, ra, rb, disp};
  endfunction

  function automatic logic [31:0] enc_opr(logic [5:0] op, reg_idx_t ra, reg_idx_t rb,
                                          bit lit, logic [7:0] litv, logic [6:0] func,
                                          reg_idx_t rc);
    return {op, ra, lit ? litv : {rb, 3'b000}, lit, func, rc};  // alpha operate layout
  endfunction

  function automatic word_t alu_ref(logic [5:0] op, logic [6:0] func, word_t a, word_t b);
    word_t r;
    r = a + b;
    if (op == OP_INTA) begin
      if (func == F_SUBQ) r = a - b;              // wraps mod 2^64
      if (func == F_CMPEQ) r = (a == b) ? 64'd1 : 64'd0;
    end else begin
      if (func == F_AND) r = a & b;
      if (func == F_BIS) r = a | b;
      if (func == F_XOR) r = a ^ b;
    end
    return r;
  endfunction

  function automatic word_t fill_word(addr_t a);
    return {16'hdead, a, ~a, 16'hbeef};  // untouched-location marker
  endfunction

  task automatic add_entry(string name, logic [5:0] op, logic [6:0] func, bit lit,
                           logic [15:0] imm, reg_idx_t src_a, reg_idx_t dst, bit rnd,
                           word_t opa, word_t opb, int outcome);
    entry_t e;
    e = '{name, op, func, lit, imm, src_a, dst, opa, opb, outcome};
    if (rnd) begin
      e.opa = {$random(seed), $random(seed)};
      e.opb = {$random(seed), $random(seed)};
    end
    table_q.push_back(e);
  endtask

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////
  task automatic check_wb(reg_idx_t exp_idx, word_t exp_data);
    checks++;
    if (wb_idx !== exp_idx || wb_data !== exp_data) begin
      errors++;
      $display("Mismatch %0t ns: writeback r%0d = %h, expected r%0d = %h",
               $time, wb_idx, wb_data, exp_idx, exp_data);
    end
  endtask

  task automatic check_word(string what, word_t exp, word_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %0t ns: %s = %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(string what, bit exp, bit got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %0t ns: %s = %0b, expected %0b", $time, what, got, exp);
    end
  endtask

  // one external access, grant sampled at posedge, read data at the next negedge
  task automatic ext_access(bit we, addr_t a, word_t d, output word_t rd);
    int n;
    rd = '0;
    if (!timed_out) begin
      @(negedge clock);
      ext_req     = 1'b1;
      ext_we      = we;
      ext_addr    = a;
      ext_wr_data = d;
      n = 0;
      do begin
        @(posedge clock);
        n++;
      end while (!ext_gnt && n < 20);
      if (!ext_gnt) begin
        timed_out = 1'b1;
        $display("timeout: external port got no grant for address %h", a);
      end
      @(negedge clock);
      ext_req = 1'b0;
      ext_we  = 1'b0;
      rd      = ext_rd_data;
    end
  endtask

  //////////////////////////////////////////////////
  // one table entry: model, load, run, read back
  //////////////////////////////////////////////////
  task automatic run_entry(int idx, entry_t e);
    logic [31:0] prog [8];
    word_t       mdl [32];     // reference register state
    reg_idx_t    q_idx [$];    // expected writebacks in program order
    word_t       q_data [$];
    word_t       res, b_val, exp_110, exp_118, got;
    int          errs_before, cyc, after;
    errs_before = errors;
    foreach (mdl[k]) mdl[k] = '0;
    // both loads take r31 as base, so the address is the displacement
    mdl[1] = e.opa;
    mdl[2] = e.opb;
    q_idx = '{5'd1, 5'd2};
    q_data = '{e.opa, e.opb};
    exp_110 = fill_word(16'h0110);
    exp_118 = fill_word(16'h0118);
    if (e.outcome == 0) begin
      if (e.op == OP_LDA) begin
        res = mdl[e.src_a] + {{48{e.imm[15]}}, e.imm};  // base rb plus displacement
      end else begin
        b_val = e.lit ? {56'd0, e.imm[7:0]} : mdl[2];
        res   = alu_ref(e.op, e.func, mdl[e.src_a], b_val);
      end
      if (e.dst != ZERO_REG) begin
        mdl[e.dst] = res;
        q_idx.push_back(e.dst);
        q_data.push_back(res);
      end
      mdl[4] = mdl[e.dst] + mdl[1];  // dependent add right behind
      q_idx.push_back(5'd4);
      q_data.push_back(mdl[4]);
      exp_110 = mdl[4];
      exp_118 = mdl[e.dst];
    end
    prog[0] = enc_mem(OP_LDQ, 5'd1, ZERO_REG, 16'h0100);
    prog[1] = enc_mem(OP_LDQ, 5'd2, ZERO_REG, 16'h0108);
    if (e.op == OP_LDA) prog[2] = enc_mem(OP_LDA, e.dst, e.src_a, e.imm);
    else if (e.op == OP_PAL) prog[2] = enc_mem(OP_PAL, 5'd0, 5'd0, e.imm);
    else prog[2] = enc_opr(e.op, e.src_a, 5'd2, e.lit, e.imm[7:0], e.func, e.dst);
    prog[3] = enc_opr(OP_INTA, e.dst, 5'd1, 1'b0, 8'd0, F_ADDQ, 5'd4);
    // first store uses r1 as base, displacement aims the sum at a fixed slot
    prog[4] = enc_mem(OP_STQ, 5'd4, 5'd1, 16'h0110 - mdl[1][15:0]);
    prog[5] = enc_mem(OP_STQ, e.dst, ZERO_REG, 16'h0118);
    prog[6] = 32'd0;  // call_pal 0
    prog[7] = 32'd0;

    run = 1'b0;
    @(negedge clock);
    arst_n = 1'b0;
    repeat (5) @(negedge clock);
    arst_n = 1'b1;
    for (int k = 0; k < 4; k++) ext_access(1'b1, 16'(k * 8), {prog[2*k+1], prog[2*k]}, got);
    ext_access(1'b1, 16'h0100, e.opa, got);
    ext_access(1'b1, 16'h0108, e.opb, got);
    ext_access(1'b1, 16'h0110, fill_word(16'h0110), got);
    ext_access(1'b1, 16'h0118, fill_word(16'h0118), got);

    if (!timed_out) begin
      @(negedge clock);
      run   = 1'b1;
      cyc   = 0;
      after = 0;
      while (after < 4 && cyc < 400) begin  // a few idle cycles past halt
        @(negedge clock);
        cyc++;
        if (wb_en) begin
          if (q_idx.size() == 0) begin
            errors++;
            $display("unexpected writeback to r%0d at %0t ns", wb_idx, $time);
          end else begin
            check_wb(q_idx.pop_front(), q_data.pop_front());
          end
        end
        if (halted) after++;
      end
      if (after == 0) begin
        timed_out = 1'b1;
        $display("timeout: halted did not rise within 400 cycles in %s", e.name);
      end else begin
        if (q_idx.size() != 0) begin
          errors++;
          $display("%0d expected writebacks never appeared, first r%0d",
                   q_idx.size(), q_idx[0]);
        end
        check_flag("illegal", e.outcome == 2, illegal);
      end
      @(negedge clock);
      run = 1'b0;
    end
    ext_access(1'b0, 16'h0110, '0, got);
    if (!timed_out) check_word("mem[0x110]", exp_110, got);
    ext_access(1'b0, 16'h0118, '0, got);
    if (!timed_out) check_word("mem[0x118]", exp_118, got);
    // still high several cycles after run dropped
    if (!timed_out) check_flag("halted", 1'b1, halted);
    $display("entry %2d %-10s %s", idx, e.name,
             timed_out ? "timeout" : (errors == errs_before) ? "ok" : "errors");
  endtask

  initial begin
    arst_n      = 1'b0;
    run         = 1'b0;
    ext_req     = 1'b0;
    ext_we      = 1'b0;
    ext_addr    = '0;
    ext_wr_data = '0;
    errors      = 0;
    checks      = 0;
    timed_out   = 1'b0;
    seed        = 32'ha191;
    // name, op, func, lit, imm, src_a, dst, rnd, opa, opb, outcome
    add_entry("addq_reg", OP_INTA, F_ADDQ, 0, 16'h0, 5'd1, 5'd3, 1, '0, '0, 0);
    add_entry("subq_reg", OP_INTA, F_SUBQ, 0, 16'h0, 5'd1, 5'd3, 1, '0, '0, 0);
    add_entry("cmpeq_ne", OP_INTA, F_CMPEQ, 0, 16'h0, 5'd1, 5'd3, 1, '0, '0, 0);
    add_entry("cmpeq_eq", OP_INTA, F_CMPEQ, 0, 16'h0, 5'd1, 5'd3, 0,
              64'h0123_4567_89ab_cdef, 64'h0123_4567_89ab_cdef, 0);
    add_entry("and_reg", OP_INTL, F_AND, 0, 16'h0, 5'd1, 5'd3, 1, '0, '0, 0);
    add_entry("bis_reg", OP_INTL, F_BIS, 0, 16'h0, 5'd1, 5'd3, 1, '0, '0, 0);
    add_entry("xor_reg", OP_INTL, F_XOR, 0, 16'h0, 5'd1, 5'd3, 1, '0, '0, 0);
    add_entry("subq_wrap", OP_INTA, F_SUBQ, 0, 16'h0, 5'd1, 5'd3, 0, 64'd5, 64'd9, 0);
    add_entry("addq_lit", OP_INTA, F_ADDQ, 1, 16'h00f3, 5'd1, 5'd3, 1, '0, '0, 0);
    add_entry("xor_lit", OP_INTL, F_XOR, 1, 16'h00a5, 5'd1, 5'd3, 1, '0, '0, 0);
    add_entry("cmpeq_lit", OP_INTA, F_CMPEQ, 1, 16'h002a, 5'd1, 5'd3, 0, 64'h2a, 64'd7, 0);
    add_entry("lda_neg", OP_LDA, 7'd0, 0, 16'hffb8, 5'd2, 5'd1, 1, '0, '0, 0);
    add_entry("lda_pos", OP_LDA, 7'd0, 0, 16'h1234, 5'd2, 5'd1, 1, '0, '0, 0);
    add_entry("dst_r31", OP_INTA, F_ADDQ, 0, 16'h0, 5'd1, ZERO_REG, 1, '0, '0, 0);
    add_entry("src_r31", OP_INTL, F_BIS, 0, 16'h0, ZERO_REG, 5'd3, 1, '0, '0, 0);
    add_entry("bad_opcode", 6'h3f, 7'd0, 0, 16'h0, 5'd1, 5'd3, 1, '0, '0, 2);
    add_entry("bad_func", OP_INTA, 7'h7f, 0, 16'h0, 5'd1, 5'd3, 1, '0, '0, 2);
    add_entry("bad_pal", OP_PAL, 7'd0, 0, 16'h0001, 5'd1, 5'd3, 1, '0, '0, 2);
    add_entry("halt_only", OP_PAL, 7'd0, 0, 16'h0, 5'd1, 5'd3, 1, '0, '0, 1);

    foreach (table_q[i]) begin
      if (!timed_out) run_entry(i, table_q[i]);
    end

    $display("%0d entries, %0d checks, %0d errors%s", table_q.size(), checks, errors,
             timed_out ? ", stopped by a timeout" : "");
    if (errors == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== dv/cpu_asserts.sv ====
// cpu_asserts: concurrent checks on memory arbitration and register writeback
`timescale 1ns/1ps

module cpu_asserts (
  input logic              clock,
  input logic              arst_n,
  input logic              ext_req,
  input logic              dm_req,
  input logic              if_req,
  input logic              ext_gnt,
  input logic              dm_gnt,
  input logic              if_gnt,
  input logic              wb_en,
  input cpu_pkg::reg_idx_t wb_idx
);
  import cpu_pkg::*;

  // single-port memory, one owner per cycle at most
  a_gnt_onehot: assert property (@(posedge clock) disable iff (!arst_n)
    $onehot0({ext_gnt, dm_gnt, if_gnt}))
    else $error("more than one memory grant in one cycle");

  a_gnt_has_req: assert property (@(posedge clock) disable iff (!arst_n)
    (!ext_gnt || ext_req) && (!dm_gnt || dm_req) && (!if_gnt || if_req))
    else $error("memory grant given without a request");

  // r31 is never a real destination
  a_no_zero_wb: assert property (@(posedge clock) disable iff (!arst_n)
    wb_en |-> (wb_idx != ZERO_REG))
    else $error("writeback names the zero register");

endmodule

// cpu_top holds both the arbiter nets and the execute writeback nets
bind cpu_top cpu_asserts asserts_0 (
  .clock   (clock),
  .arst_n  (arst_n),
  .ext_req (ext_req),
  .dm_req  (dm_req),
  .if_req  (if_req),
  .ext_gnt (ext_gnt),
  .dm_gnt  (dm_gnt),
  .if_gnt  (if_gnt),
  .wb_en   (wb_en),
  .wb_idx  (wb_idx)
);

// ==== src/cpu_top.sv ====
// cpu_top: fetch, decode and execute stages sharing one memory with an external port
`timescale 1ns/1ps

module cpu_top (
  input  logic              clock,
  input  logic              arst_n,
  input  logic              run,
  input  logic              ext_req,
  input  logic              ext_we,
  input  cpu_pkg::addr_t    ext_addr,
  input  cpu_pkg::word_t    ext_wr_data,
  output logic              ext_gnt,
  output cpu_pkg::word_t    ext_rd_data,
  output logic              wb_en,
  output cpu_pkg::reg_idx_t wb_idx,
  output cpu_pkg::word_t    wb_data,
  output logic              halted,
  output logic              illegal
);
  import cpu_pkg::*;

  inst_t     inst;
  logic      inst_valid, ex_ready, if_req, if_gnt, dm_req, dm_gnt, dm_we;
  addr_t     if_addr, dm_addr;
  word_t     mem_rd_data, rda, rdb, imm, dm_wr_data;
  opb_sel_e  opb_sel;
  alu_func_e alu_func;
  reg_idx_t  dest_idx;
  logic      rd_mem, wr_mem, halt, dec_illegal, dec_valid;

  assign ext_rd_data = mem_rd_data;  // one shared read bus

  if_stage if_stage_0 (
    .clock (clock), .arst_n (arst_n), .run (run), .stop (halted),
    .ex_ready (ex_ready), .if_gnt (if_gnt), .mem_rd_data (mem_rd_data),
    .if_req (if_req), .if_addr (if_addr), .inst (inst),
    .inst_valid (inst_valid), .npc ()
  );

  id_stage id_stage_0 (
    .clock (clock), .arst_n (arst_n), .inst (inst), .inst_valid (inst_valid),
    .wb_en (wb_en), .wb_idx (wb_idx), .wb_data (wb_data),
    .rda (rda), .rdb (rdb), .imm (imm), .opb_sel (opb_sel), .alu_func (alu_func),
    .dest_idx (dest_idx), .rd_mem (rd_mem), .wr_mem (wr_mem), .halt (halt),
    .illegal (dec_illegal), .dec_valid (dec_valid)
  );

  ex_stage ex_stage_0 (
    .clock (clock), .arst_n (arst_n), .rda (rda), .rdb (rdb), .imm (imm),
    .opb_sel (opb_sel), .alu_func (alu_func), .dest_idx (dest_idx),
    .rd_mem (rd_mem), .wr_mem (wr_mem), .halt (halt), .illegal (dec_illegal),
    .dec_valid (dec_valid), .dm_gnt (dm_gnt), .mem_rd_data (mem_rd_data),
    .ex_ready (ex_ready), .dm_req (dm_req), .dm_we (dm_we), .dm_addr (dm_addr),
    .dm_wr_data (dm_wr_data), .wb_en (wb_en), .wb_idx (wb_idx), .wb_data (wb_data),
    .halted (halted), .illegal_halt (illegal)
  );

  unified_mem unified_mem_0 (
    .clock (clock), .arst_n (arst_n),
    .ext_req (ext_req), .ext_we (ext_we), .ext_addr (ext_addr), .ext_wr_data (ext_wr_data),
    .dm_req (dm_req), .dm_we (dm_we), .dm_addr (dm_addr), .dm_wr_data (dm_wr_data),
    .if_req (if_req), .if_addr (if_addr),
    .ext_gnt (ext_gnt), .dm_gnt (dm_gnt), .if_gnt (if_gnt), .mem_rd_data (mem_rd_data)
  );

endmodule

// ==== src/unified_mem.sv ====
// unified_mem: shared instruction/data memory behind a fixed-priority three-way arbiter
`timescale 1ns/1ps

module unified_mem (
  input  logic           clock,
  input  logic           arst_n,
  // external load port, highest priority
  input  logic           ext_req,
  input  logic           ext_we,
  input  cpu_pkg::addr_t ext_addr,
  input  cpu_pkg::word_t ext_wr_data,
  // execute stage data port
  input  logic           dm_req,
  input  logic           dm_we,
  input  cpu_pkg::addr_t dm_addr,
  input  cpu_pkg::word_t dm_wr_data,
  // fetch port, read only, lowest priority
  input  logic           if_req,
  input  cpu_pkg::addr_t if_addr,
  output logic           ext_gnt,
  output logic           dm_gnt,
  output logic           if_gnt,
  output cpu_pkg::word_t mem_rd_data
);
  import cpu_pkg::*;

  word_t             mem [MEM_WORDS];
  addr_t             sel_addr;
  word_t             sel_wr_data;
  logic              sel_we;
  logic              any_gnt;
  logic [MEM_AW-1:0] word_idx;

  //////////////////////////////////////////////////
  // arbiter: ext > data > fetch
  //////////////////////////////////////////////////
  assign ext_gnt = ext_req;
  assign dm_gnt  = dm_req && !ext_req;
  assign if_gnt  = if_req && !ext_req && !dm_req;
  assign any_gnt = ext_gnt || dm_gnt || if_gnt;

  // steer the winner onto the single port
  always_comb begin
    if (ext_gnt) begin
      sel_addr    = ext_addr;
      sel_wr_data = ext_wr_data;
      sel_we      = ext_we;
    end else if (dm_gnt) begin
      sel_addr    = dm_addr;
      sel_wr_data = dm_wr_data;
      sel_we      = dm_we;
    end else begin
      sel_addr    = if_addr;
      sel_wr_data = dm_wr_data;  // fetch never writes
      sel_we      = 1'b0;
    end
  end

  assign word_idx = sel_addr[3 +: MEM_AW];  // double-word index

  always_ff @(posedge clock) begin
    if (any_gnt && sel_we) mem[word_idx] <= sel_wr_data;  // write ends the grant cycle
  end

  // read data lands the cycle after the grant
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) mem_rd_data <= '0;
    else if (any_gnt) mem_rd_data <= mem[word_idx];
  end

endmodule

// ==== src/ex_stage.sv ====
// ex_stage: alu, data memory access and register writeback, one instruction in flight
`timescale 1ns/1ps

module ex_stage (
  input  logic               clock,
  input  logic               arst_n,
  input  cpu_pkg::word_t     rda,
  input  cpu_pkg::word_t     rdb,
  input  cpu_pkg::word_t     imm,
  input  cpu_pkg::opb_sel_e  opb_sel,
  input  cpu_pkg::alu_func_e alu_func,
  input  cpu_pkg::reg_idx_t  dest_idx,
  input  logic               rd_mem,
  input  logic               wr_mem,
  input  logic               halt,
  input  logic               illegal,
  input  logic               dec_valid,
  input  logic               dm_gnt,
  input  cpu_pkg::word_t     mem_rd_data,
  output logic               ex_ready,
  output logic               dm_req,
  output logic               dm_we,
  output cpu_pkg::addr_t     dm_addr,
  output cpu_pkg::word_t     dm_wr_data,
  output logic               wb_en,
  output cpu_pkg::reg_idx_t  wb_idx,
  output cpu_pkg::word_t     wb_data,
  output logic               halted,
  output logic               illegal_halt
);
  import cpu_pkg::*;

  logic      busy, ld_wait, retire, stop_now, capture;
  logic      rd_q, wr_q, halt_q, ill_q;
  word_t     opa_q, opb_q, st_q, alu_res;
  alu_func_e func_q;
  reg_idx_t  dest_q;

  //////////////////////////////////////////////////
  // alu on the captured operands
  //////////////////////////////////////////////////
  always_comb begin
    case (func_q)
      ALU_SUB:   alu_res = opa_q - opb_q;  // wraps mod 2^64
      ALU_CMPEQ: alu_res = {63'd0, opa_q == opb_q};
      ALU_AND:   alu_res = opa_q & opb_q;
      ALU_OR:    alu_res = opa_q | opb_q;
      ALU_XOR:   alu_res = opa_q ^ opb_q;
      default:   alu_res = opa_q + opb_q;  // add, lda and memory address
    endcase
  end

  // plain ops leave after one cycle, stq on its grant, ldq when data is back
  assign retire   = busy && ((!rd_q && !wr_q) || (wr_q && dm_gnt) || ld_wait);
  assign stop_now = retire && (halt_q || ill_q);
  assign ex_ready = (!busy || retire) && !halted && !stop_now;
  assign capture  = dec_valid && ex_ready;

  assign dm_req     = busy && (rd_q || wr_q) && !ld_wait;
  assign dm_we      = wr_q;
  assign dm_addr    = alu_res[15:0];
  assign dm_wr_data = st_q;                   // store data came in on rda

  assign wb_en   = retire && (dest_q != ZERO_REG);
  assign wb_idx  = dest_q;
  assign wb_data = ld_wait ? mem_rd_data : alu_res;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      busy         <= 1'b0;
      ld_wait      <= 1'b0;
      halted       <= 1'b0;
      illegal_halt <= 1'b0;
    end else begin
      if (capture) busy <= 1'b1;
      else if (retire) busy <= 1'b0;
      ld_wait <= dm_req && dm_gnt && rd_q;    // data due next cycle
      if (stop_now) begin
        halted       <= 1'b1;                 // sticky until reset
        illegal_halt <= ill_q;
      end
    end
  end

  // instruction payload
  always_ff @(posedge clock) begin
    if (capture) begin
      opa_q  <= (opb_sel == OPB_DISP) ? rdb : rda;  // memory forms add to base rb
      opb_q  <= (opb_sel == OPB_REG) ? rdb : imm;
      st_q   <= rda;
      func_q <= alu_func;
      dest_q <= dest_idx;
      rd_q   <= rd_mem;
      wr_q   <= wr_mem;
      halt_q <= halt;
      ill_q  <= illegal;
    end
  end

endmodule

// ==== src/if_stage.sv ====
// if_stage: program counter, fetch requests to the shared memory, fetch/decode register
`timescale 1ns/1ps

module if_stage (
  input  logic            clock,
  input  logic            arst_n,
  input  logic            run,
  input  logic            stop,         // halt or illegal retired
  input  logic            ex_ready,
  input  logic            if_gnt,
  input  cpu_pkg::word_t  mem_rd_data,
  output logic            if_req,
  output cpu_pkg::addr_t  if_addr,
  output cpu_pkg::inst_t  inst,
  output logic            inst_valid,
  output cpu_pkg::addr_t  npc
);
  import cpu_pkg::*;

  addr_t pc;
  logic  run_q;    // delays the first request by one cycle
  logic  rd_pend;  // granted last cycle, data on the bus now

  assign npc     = pc + 16'd4;
  assign if_addr = pc;  // memory drops the low three bits
  // ask again once the held instruction leaves this cycle
  assign if_req  = run_q && !stop && !rd_pend && (!inst_valid || ex_ready);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      pc         <= '0;
      run_q      <= 1'b0;
      rd_pend    <= 1'b0;
      inst_valid <= 1'b0;
    end else begin
      run_q   <= run;
      rd_pend <= if_gnt;
      if (rd_pend) begin
        pc         <= npc;
        inst_valid <= !stop;  // anything fetched past a halt is dropped
      end else if (inst_valid && ex_ready) begin
        inst_valid <= 1'b0;   // taken by execute
      end
    end
  end

  // instruction payload, half picked by pc[2]
  always_ff @(posedge clock) begin
    if (rd_pend) inst <= pc[2] ? mem_rd_data[63:32] : mem_rd_data[31:0];
  end

endmodule

// ==== src/id_stage.sv ====
// id_stage: decodes the fetched word, reads both source registers, forms the immediate
`timescale 1ns/1ps

module id_stage (
  input  logic               clock,
  input  logic               arst_n,
  input  cpu_pkg::inst_t     inst,
  input  logic               inst_valid,
  input  logic               wb_en,
  input  cpu_pkg::reg_idx_t  wb_idx,
  input  cpu_pkg::word_t     wb_data,
  output cpu_pkg::word_t     rda,
  output cpu_pkg::word_t     rdb,
  output cpu_pkg::word_t     imm,
  output cpu_pkg::opb_sel_e  opb_sel,
  output cpu_pkg::alu_func_e alu_func,
  output cpu_pkg::reg_idx_t  dest_idx,
  output logic               rd_mem,
  output logic               wr_mem,
  output logic               halt,
  output logic               illegal,
  output logic               dec_valid
);
  import cpu_pkg::*;

  // ra/rb sit in the same bits in both formats, stq store data comes out on rda
  regfile regf_0 (
    .clock   (clock),
    .arst_n  (arst_n),
    .rda_idx (inst.m.ra),
    .rdb_idx (inst.m.rb),
    .wr_idx  (wb_idx),
    .wr_data (wb_data),
    .wr_en   (wb_en),
    .rda_out (rda),
    .rdb_out (rdb)
  );

  decoder decoder_0 (
    .inst       (inst),
    .inst_valid (inst_valid),
    .opb_sel    (opb_sel),
    .alu_func   (alu_func),
    .dest_idx   (dest_idx),
    .rd_mem     (rd_mem),
    .wr_mem     (wr_mem),
    .halt       (halt),
    .illegal    (illegal),
    .dec_valid  (dec_valid)
  );

  // literal through the operate view, displacement through the memory view
  assign imm = (opb_sel == OPB_LIT) ? {56'd0, inst.r.opb.lit}
                                    : {{48{inst.m.disp[15]}}, inst.m.disp};

endmodule

// ==== src/decoder.sv ====
// decoder: turns one instruction word into operand select, alu op, memory and stop controls
`timescale 1ns/1ps

module decoder (
  input  cpu_pkg::inst_t    inst,
  input  logic              inst_valid,
  output cpu_pkg::opb_sel_e  opb_sel,
  output cpu_pkg::alu_func_e alu_func,
  output cpu_pkg::reg_idx_t  dest_idx,
  output logic              rd_mem,
  output logic              wr_mem,
  output logic              halt,
  output logic              illegal,
  output logic              dec_valid
);
  import cpu_pkg::*;

  assign dec_valid = inst_valid;

  always_comb begin
    // quiet defaults, also the state while nothing is valid
    opb_sel  = OPB_REG;
    alu_func = ALU_ADD;
    dest_idx = ZERO_REG;
    rd_mem   = 1'b0;
    wr_mem   = 1'b0;
    halt     = 1'b0;
    illegal  = 1'b0;
    if (inst_valid) begin
      case (inst.m.opcode)
        OP_PAL: begin
          // call_pal 0 is halt, any other pal function is unsupported
          if ({inst.m.ra, inst.m.rb, inst.m.disp} == 26'd0) halt = 1'b1;
          else illegal = 1'b1;
        end
        OP_LDA, OP_LDQ: begin
          opb_sel  = OPB_DISP;       // ra <- rb + disp, or mem[rb + disp]
          dest_idx = inst.m.ra;
          rd_mem   = (inst.m.opcode == OP_LDQ);
        end
        OP_STQ: begin
          opb_sel = OPB_DISP;        // address only, no register result
          wr_mem  = 1'b1;
        end
        OP_INTA, OP_INTL: begin
          opb_sel  = inst.r.lit_flag ? OPB_LIT : OPB_REG;
          dest_idx = inst.r.dest_idx;
          if (inst.r.opcode == OP_INTA) begin
            case (inst.r.func)
              F_ADDQ:  alu_func = ALU_ADD;
              F_SUBQ:  alu_func = ALU_SUB;
              F_CMPEQ: alu_func = ALU_CMPEQ;
              default: illegal  = 1'b1;
            endcase
          end else begin
            case (inst.r.func)
              F_AND:   alu_func = ALU_AND;
              F_BIS:   alu_func = ALU_OR;
              F_XOR:   alu_func = ALU_XOR;
              default: illegal  = 1'b1;
            endcase
          end
          if (illegal) dest_idx = ZERO_REG;  // bad func must not write back
        end
        default: illegal = 1'b1;
      endcase
    end
  end

endmodule

// ==== src/regfile.sv ====
// regfile: 32 x 64-bit integer registers, r31 fixed at zero, write-to-read bypass
`timescale 1ns/1ps

module regfile (
  input  logic             clock,
  input  logic             arst_n,
  input  cpu_pkg::reg_idx_t rda_idx,
  input  cpu_pkg::reg_idx_t rdb_idx,
  input  cpu_pkg::reg_idx_t wr_idx,
  input  cpu_pkg::word_t    wr_data,
  input  logic             wr_en,
  output cpu_pkg::word_t    rda_out,
  output cpu_pkg::word_t    rdb_out
);
  import cpu_pkg::*;

  word_t regs [32];

  // read ports, zero reg first, then same-cycle bypass
  always_comb begin
    if (rda_idx == ZERO_REG) rda_out = '0;
    else if (wr_en && (wr_idx == rda_idx)) rda_out = wr_data;
    else rda_out = regs[rda_idx];
  end

  always_comb begin
    if (rdb_idx == ZERO_REG) rdb_out = '0;
    else if (wr_en && (wr_idx == rdb_idx)) rdb_out = wr_data;
    else rdb_out = regs[rdb_idx];
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (wr_en && (wr_idx != ZERO_REG)) begin
      regs[wr_idx] <= wr_data;  // r31 writes fall away here
    end
  end

endmodule

// ==== src/cpu_pkg.sv ====
// cpu_pkg: shared widths, opcodes, function codes and decode types for the core
package cpu_pkg;

  typedef logic [63:0] word_t;     // register and data word
  typedef logic [15:0] addr_t;     // byte address
  typedef logic [4:0]  reg_idx_t;  // architectural register index

  localparam int       MEM_WORDS = 512;                // double-words in the unified memory
  localparam int       MEM_AW    = $clog2(MEM_WORDS);  // double-word index width
  localparam reg_idx_t ZERO_REG  = 5'd31;              // reads zero, writes dropped

  //////////////////////////////////////////////////
  // major opcodes
  //////////////////////////////////////////////////
  localparam logic [5:0] OP_PAL  = 6'h00;  // call_pal, only halt supported
  localparam logic [5:0] OP_LDA  = 6'h08;
  localparam logic [5:0] OP_INTA = 6'h10;  // integer arithmetic group
  localparam logic [5:0] OP_INTL = 6'h11;  // integer logical group
  localparam logic [5:0] OP_LDQ  = 6'h29;
  localparam logic [5:0] OP_STQ  = 6'h2D;

  // function codes, inta group
  localparam logic [6:0] F_ADDQ  = 7'h20;
  localparam logic [6:0] F_SUBQ  = 7'h29;
  localparam logic [6:0] F_CMPEQ = 7'h2D;
  // function codes, intl group
  localparam logic [6:0] F_AND   = 7'h00;
  localparam logic [6:0] F_BIS   = 7'h20;
  localparam logic [6:0] F_XOR   = 7'h40;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_CMPEQ, ALU_AND, ALU_OR, ALU_XOR
  } alu_func_e;

  typedef enum logic [1:0] {
    OPB_REG,   // register b
    OPB_LIT,   // 8-bit literal, zero extended
    OPB_DISP   // 16-bit displacement, sign extended
  } opb_sel_e;

  // one instruction word, seen as memory format or operate format
  typedef union packed {
    struct packed {
      logic [5:0]  opcode;
      reg_idx_t    ra;
      reg_idx_t    rb;
      logic [15:0] disp;
    } m;
    struct packed {
      logic [5:0] opcode;
      reg_idx_t   rega_idx;
      union packed {
        struct packed {
          reg_idx_t   regb_idx;
          logic [2:0] sbz;       // should be zero in register form
        } rb;
        logic [7:0] lit;
      } opb;
      logic       lit_flag;      // 1 selects the literal
      logic [6:0] func;
      reg_idx_t   dest_idx;
    } r;
  } inst_t;

endpackage
